// File: rtl/ts_pkg.sv
package ts_pkg;

    // scanline buffer geometry
    localparam int LINE_W = 512;
    // x coordinate and line buffer address width
    localparam int XC_W = 9;

    // slotted dram word port
    localparam int DADDR_W = 21;
    localparam int DDATA_W = 16;

    // palette nibble over colour index nibble
    localparam int PIX_W = 8;

    // task queue depth, equal to the host's starting credits
    localparam int TASK_DEPTH = 4;
    localparam int TASK_PTR_W = $clog2(TASK_DEPTH);
    // occupancy and pending returns go up to TASK_DEPTH
    localparam int TASK_CNT_W = $clog2(TASK_DEPTH + 1);

    // packed descriptor: x_coord, x_size, flip, addr, line, page, pal
    localparam int DESC_W = XC_W + 3 + 1 + 6 + 9 + 8 + 4;

    // four clocks per dram slot
    typedef enum logic [1:0] {
        slot_c0,
        slot_c1,
        slot_c2,
        slot_c3
    } slot_phase_t;

    // queue issue machine
    typedef enum logic {
        q_idle,
        q_issue
    } queue_state_t;

endpackage

// File: rtl/ts_task_queue.sv
module ts_task_queue (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    line_start,
    input  logic                    task_valid,
    input  logic [ts_pkg::XC_W-1:0] x_coord,
    input  logic [2:0]              x_size,
    input  logic                    flip,
    input  logic [5:0]              addr,
    input  logic [8:0]              line,
    input  logic [7:0]              page,
    input  logic [3:0]              pal,
    input  logic                    mem_rdy,
    output logic                    credit_return,
    output logic                    tsr_go,
    output logic [ts_pkg::XC_W-1:0] go_x_coord,
    output logic [2:0]              go_x_size,
    output logic                    go_flip,
    output logic [5:0]              go_addr,
    output logic [8:0]              go_line,
    output logic [7:0]              go_page,
    output logic [3:0]              go_pal,
    output logic                    idle,
    input  logic                    render_busy
);
    import ts_pkg::*;

    queue_state_t          state;
    logic [DESC_W-1:0]     desc_mem [TASK_DEPTH];
    logic [TASK_PTR_W-1:0] wr_ptr;
    logic [TASK_PTR_W-1:0] rd_ptr;
    logic [TASK_CNT_W-1:0] count;
    logic [TASK_CNT_W-1:0] ret_pend;
    logic [TASK_CNT_W-1:0] flushed;
    logic                  full;
    logic                  empty;
    logic                  push;
    logic                  ret_now;

    assign full  = (count == TASK_CNT_W'(TASK_DEPTH));
    assign empty = (count == '0);
    // a task arriving with line_start is dropped and its credit handed back
    assign push  = task_valid && !full && !line_start;

    // pop straight into a ready renderer
    assign tsr_go = (state == q_issue) && !empty && mem_rdy && !line_start;

    // flushed credits trickle back in cycles without a pop
    assign ret_now       = (ret_pend != '0) && !tsr_go;
    assign credit_return = tsr_go || ret_now;

    // everything still queued plus a same-cycle arrival
    assign flushed = count + TASK_CNT_W'(task_valid && !full);

    assign {go_x_coord, go_x_size, go_flip, go_addr, go_line, go_page, go_pal} =
        desc_mem[rd_ptr];

    assign idle = (state == q_idle);

    // descriptor storage
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            desc_mem[wr_ptr] <= {x_coord, x_size, flip, addr, line, page, pal};
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            ret_pend <= '0;
            state    <= q_idle;
        end
        else if (line_start)
        begin
            // flush, queued credits join the pending returns
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            ret_pend <= ret_pend + flushed - TASK_CNT_W'(ret_now);
            state    <= q_idle;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (tsr_go)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + TASK_CNT_W'(push) - TASK_CNT_W'(tsr_go);
            if (ret_now)
                ret_pend <= ret_pend - 1'b1;

            case (state)
                q_idle:
                begin
                    if (push || !empty)
                        state <= q_issue;
                end
                q_issue:
                begin
                    // done once drained and the renderer has stopped writing
                    if (empty && !push && !render_busy)
                        state <= q_idle;
                end
                default:
                    state <= q_idle;
            endcase
        end
    end

endmodule

// File: rtl/dram_slot_timer.sv
module dram_slot_timer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       dram_req,
    input  logic [ts_pkg::DADDR_W-1:0] dram_addr,
    input  logic [ts_pkg::DDATA_W-1:0] mem_rdata,
    output logic                       dram_pre_next,
    output logic                       dram_next,
    output logic [ts_pkg::DDATA_W-1:0] dram_rdata,
    output logic                       mem_rd,
    output logic [ts_pkg::DADDR_W-1:0] mem_addr
);
    import ts_pkg::*;

    slot_phase_t        phase;
    logic               granted;
    logic [DADDR_W-1:0] addr_q;

    assign mem_addr = addr_q;

    // free running slot phase, c0 after reset
    always_ff @(posedge clk)
    begin
        if (reset)
            phase <= slot_c0;
        else
            phase <= slot_phase_t'(phase + 2'd1);
    end

    // strobes registered so each lands on its own phase
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            granted       <= 1'b0;
            mem_rd        <= 1'b0;
            dram_pre_next <= 1'b0;
            dram_next     <= 1'b0;
        end
        else
        begin
            // grant decided at c0, read goes out in c1
            if (phase == slot_c0)
                granted <= dram_req;
            mem_rd        <= (phase == slot_c0) && dram_req;
            // pre_next in c2, next in c3
            dram_pre_next <= (phase == slot_c1) && granted;
            dram_next     <= (phase == slot_c2) && granted;
        end
    end

    // address latch at grant
    always_ff @(posedge clk)
    begin
        if (phase == slot_c0 && dram_req)
            addr_q <= dram_addr;
    end

    // word returns in c2, held for the renderer until the next slot
    always_ff @(posedge clk)
    begin
        if (phase == slot_c2 && granted)
            dram_rdata <= mem_rdata;
    end

endmodule

// File: rtl/ts_render.sv
module ts_render (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       line_start,
    input  logic [ts_pkg::XC_W-1:0]    x_coord,
    input  logic [2:0]                 x_size,
    input  logic                       flip,
    input  logic                       tsr_go,
    input  logic [5:0]                 addr,
    input  logic [8:0]                 line,
    input  logic [7:0]                 page,
    input  logic [3:0]                 pal,
    output logic                       mem_rdy,
    output logic                       render_busy,
    output logic [ts_pkg::XC_W-1:0]    ts_waddr,
    output logic [ts_pkg::PIX_W-1:0]   ts_wdata,
    output logic                       ts_we,
    output logic [ts_pkg::DADDR_W-1:0] dram_addr,
    output logic                       dram_req,
    input  logic [ts_pkg::DDATA_W-1:0] dram_rdata,
    input  logic                       dram_pre_next,
    input  logic                       dram_next
);
    import ts_pkg::*;

    logic               restart;
    logic [13:0]        addr_offset;
    logic [DADDR_W-1:0] addr_in;
    logic [DADDR_W-1:0] addr_reg;
    logic [DADDR_W-1:0] addr_next;
    logic [4:0]         cyc;
    logic               own_pre_next;
    logic               own_pre_d;
    logic               own_next;
    logic [11:0]        data;
    logic [2:0]         cnt;
    logic               render_on;
    logic               tsr_rld;
    logic               tsr_rld_stb;
    logic [XC_W-1:0]    x_coord_d;
    logic [3:0]         pal_d;
    logic               flip_d;
    logic [3:0]         pal_r;
    logic               flip_r;
    logic [XC_W-1:0]    x_next;
    logic [XC_W-1:0]    ts_waddr_mx;
    logic [3:0]         pix;

    // line start restarts the machine just like reset
    assign restart = reset || line_start;

    // request from go until the last slot has been counted
    assign dram_req = tsr_go || !mem_rdy;

    // word address, (page*64 + line)*128 + addr*2
    assign addr_offset = {page, 6'b0} + {5'b0, line};
    assign addr_in     = {addr_offset, addr, 1'b0};
    // only the low 7 bits move, a strip never leaves its bitmap line
    assign addr_next   = {addr_reg[DADDR_W-1:7], addr_reg[6:0] + {6'b0, own_next}};
    assign dram_addr   = tsr_go ? addr_in : addr_next;

    always_ff @(posedge clk)
    begin
        addr_reg <= dram_addr;
    end

    // only strobes of our own slots count
    // stale slots after line_start arrive while mem_rdy is high
    assign own_pre_next = dram_pre_next && !mem_rdy;
    assign own_next     = dram_next && own_pre_d;

    always_ff @(posedge clk)
    begin
        if (restart)
            own_pre_d <= 1'b0;
        else
            own_pre_d <= own_pre_next;
    end

    // slot counter, two words per 8 pixels; bit 4 set means ready
    assign mem_rdy = cyc[4];

    always_ff @(posedge clk)
    begin
        if (restart)
            cyc <= 5'b10000;
        else if (tsr_go)
            cyc <= {1'b0, x_size, 1'b1};
        else if (own_pre_next)
            cyc <= cyc - 5'd1;
    end

    // keep the last three nibbles of the word for the following cycles
    always_ff @(posedge clk)
    begin
        if (own_next)
            data <= {dram_rdata[3:0], dram_rdata[15:8]};
    end

    // pixel counter, four pixels starting at dram_next
    assign render_on = !cnt[2];

    always_ff @(posedge clk)
    begin
        if (restart)
            cnt <= 3'b100;
        else if (own_pre_next)
            cnt <= 3'b000;
        else if (render_on)
            cnt <= cnt + 3'd1;
    end

    // reload pending until the first slot of the new task
    always_ff @(posedge clk)
    begin
        if (restart)
            tsr_rld <= 1'b0;
        else if (tsr_go)
            tsr_rld <= 1'b1;
        else if (own_pre_next)
            tsr_rld <= 1'b0;
    end

    assign tsr_rld_stb = tsr_rld && own_pre_next;

    // task fields parked until the previous strip has drained
    // flipped start is the far end of the strip, wraps modulo 512
    always_ff @(posedge clk)
    begin
        if (tsr_go)
        begin
            x_coord_d <= x_coord + (flip ? {3'b0, x_size, 3'b111} : '0);
            pal_d     <= pal;
            flip_d    <= flip;
        end
    end

    always_ff @(posedge clk)
    begin
        if (tsr_rld_stb)
        begin
            pal_r  <= pal_d;
            flip_r <= flip_d;
        end
    end

    // destination steps up, or down when flipped
    assign x_next      = ts_waddr + {{(XC_W-1){flip_r}}, 1'b1};
    assign ts_waddr_mx = tsr_rld_stb ? x_coord_d : (render_on ? x_next : ts_waddr);

    always_ff @(posedge clk)
    begin
        ts_waddr <= ts_waddr_mx;
    end

    // nibble order per word: [7:4], [3:0], [15:12], [11:8]
    always_comb
    begin
        case (cnt[1:0])
            2'd0:    pix = dram_rdata[7:4];
            2'd1:    pix = data[11:8];
            2'd2:    pix = data[7:4];
            default: pix = data[3:0];
        endcase
    end

    // index 0 is transparent
    assign ts_wdata = {pal_r, pix};
    assign ts_we    = render_on && (pix != 4'd0);

    // busy while slots or pixel writes remain
    assign render_busy = !mem_rdy || render_on;

endmodule

// File: rtl/ts_line_buf.sv
module ts_line_buf (
    input  logic                     clk,
    input  logic [ts_pkg::XC_W-1:0]  ts_waddr,
    input  logic [ts_pkg::PIX_W-1:0] ts_wdata,
    input  logic                     ts_we,
    input  logic                     rd_en,
    input  logic [ts_pkg::XC_W-1:0]  rd_addr,
    output logic [ts_pkg::PIX_W-1:0] rd_data
);
    import ts_pkg::*;

    // one byte per pixel of the line
    logic [PIX_W-1:0] mem [LINE_W];

    // scanout side
    // registered read, one cycle latency
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

    // write side
    // the entry read out is zeroed for the next line
    // a render write on the same edge lands after the clear and wins
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            mem[rd_addr] <= '0;
        end
        if (ts_we)
        begin
            mem[ts_waddr] <= ts_wdata;
        end
    end

endmodule

// File: rtl/ts_line_top.sv
module ts_line_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       line_start,
    input  logic                       task_valid,
    input  logic [ts_pkg::XC_W-1:0]    x_coord,
    input  logic [2:0]                 x_size,
    input  logic                       flip,
    input  logic [5:0]                 addr,
    input  logic [8:0]                 line,
    input  logic [7:0]                 page,
    input  logic [3:0]                 pal,
    output logic                       credit_return,
    output logic                       idle,
    output logic                       mem_rd,
    output logic [ts_pkg::DADDR_W-1:0] mem_addr,
    input  logic [ts_pkg::DDATA_W-1:0] mem_rdata,
    input  logic                       rd_en,
    input  logic [ts_pkg::XC_W-1:0]    rd_addr,
    output logic [ts_pkg::PIX_W-1:0]   rd_data
);
    import ts_pkg::*;

    // queue to renderer
    logic               tsr_go;
    logic [XC_W-1:0]    go_x_coord;
    logic [2:0]         go_x_size;
    logic               go_flip;
    logic [5:0]         go_addr;
    logic [8:0]         go_line;
    logic [7:0]         go_page;
    logic [3:0]         go_pal;
    logic               mem_rdy;
    logic               render_busy;
    // renderer to slot timer and back
    logic               dram_req;
    logic [DADDR_W-1:0] dram_addr;
    logic [DDATA_W-1:0] dram_rdata;
    logic               dram_pre_next;
    logic               dram_next;
    // renderer to line buffer
    logic [XC_W-1:0]    ts_waddr;
    logic [PIX_W-1:0]   ts_wdata;
    logic               ts_we;

    ts_task_queue i_queue (
        .clk           (clk),
        .reset         (reset),
        .line_start    (line_start),
        .task_valid    (task_valid),
        .x_coord       (x_coord),
        .x_size        (x_size),
        .flip          (flip),
        .addr          (addr),
        .line          (line),
        .page          (page),
        .pal           (pal),
        .mem_rdy       (mem_rdy),
        .credit_return (credit_return),
        .tsr_go        (tsr_go),
        .go_x_coord    (go_x_coord),
        .go_x_size     (go_x_size),
        .go_flip       (go_flip),
        .go_addr       (go_addr),
        .go_line       (go_line),
        .go_page       (go_page),
        .go_pal        (go_pal),
        .idle          (idle),
        .render_busy   (render_busy)
    );

    dram_slot_timer i_slot_timer (
        .clk           (clk),
        .reset         (reset),
        .dram_req      (dram_req),
        .dram_addr     (dram_addr),
        .mem_rdata     (mem_rdata),
        .dram_pre_next (dram_pre_next),
        .dram_next     (dram_next),
        .dram_rdata    (dram_rdata),
        .mem_rd        (mem_rd),
        .mem_addr      (mem_addr)
    );

    ts_render i_render (
        .clk           (clk),
        .reset         (reset),
        .line_start    (line_start),
        .x_coord       (go_x_coord),
        .x_size        (go_x_size),
        .flip          (go_flip),
        .tsr_go        (tsr_go),
        .addr          (go_addr),
        .line          (go_line),
        .page          (go_page),
        .pal           (go_pal),
        .mem_rdy       (mem_rdy),
        .render_busy   (render_busy),
        .ts_waddr      (ts_waddr),
        .ts_wdata      (ts_wdata),
        .ts_we         (ts_we),
        .dram_addr     (dram_addr),
        .dram_req      (dram_req),
        .dram_rdata    (dram_rdata),
        .dram_pre_next (dram_pre_next),
        .dram_next     (dram_next)
    );

    ts_line_buf i_line_buf (
        .clk      (clk),
        .ts_waddr (ts_waddr),
        .ts_wdata (ts_wdata),
        .ts_we    (ts_we),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule

// File: dv/ts_mem_model.sv
module ts_mem_model (
    input  logic                       clk,
    input  logic                       mem_rd,
    input  logic [ts_pkg::DADDR_W-1:0] mem_addr,
    output logic [ts_pkg::DDATA_W-1:0] mem_rdata
);
    timeunit 1ns;
    timeprecision 100ps;
    import ts_pkg::*;

    logic [DDATA_W-1:0] product;

    // word content is a fixed hash of the low address bits
    assign product = mem_addr[15:0] * 16'h9e37;

    // defined value before the first read
    initial
    begin
        mem_rdata = '0;
    end

    // answer one cycle after the read strobe, then hold
    always @(posedge clk)
    begin
        if (mem_rd)
        begin
            mem_rdata <= product ^ 16'h5a5a;
        end
    end

endmodule

// File: dv/ts_line_tb.sv
module ts_line_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ts_pkg::*;

    localparam int IDLE_TIMEOUT = 5000;

    typedef struct packed {
        logic [XC_W-1:0] x_coord;
        logic [2:0]      x_size;
        logic            flip;
        logic [5:0]      addr;
        logic [8:0]      line;
        logic [7:0]      page;
        logic [3:0]      pal;
    } task_t;

    logic               clk;
    logic               reset;
    logic               line_start;
    logic               task_valid;
    logic [XC_W-1:0]    x_coord;
    logic [2:0]         x_size;
    logic               flip;
    logic [5:0]         addr;
    logic [8:0]         line;
    logic [7:0]         page;
    logic [3:0]         pal;
    logic               credit_return;
    logic               idle;
    logic               mem_rd;
    logic [DADDR_W-1:0] mem_addr;
    logic [DDATA_W-1:0] mem_rdata;
    logic               rd_en;
    logic [XC_W-1:0]    rd_addr;
    logic [PIX_W-1:0]   rd_data;

    // tasks of the current line in send order
    task_t            task_list[$];
    logic [PIX_W-1:0] exp_line [LINE_W];
    int               sent = 0;
    int               returns = 0;
    bit               check_on = 1'b0;
    logic             chk_valid;
    logic [XC_W-1:0]  chk_addr;

    ts_line_top i_ts_line_top (
        .clk           (clk),
        .reset         (reset),
        .line_start    (line_start),
        .task_valid    (task_valid),
        .x_coord       (x_coord),
        .x_size        (x_size),
        .flip          (flip),
        .addr          (addr),
        .line          (line),
        .page          (page),
        .pal           (pal),
        .credit_return (credit_return),
        .idle          (idle),
        .mem_rd        (mem_rd),
        .mem_addr      (mem_addr),
        .mem_rdata     (mem_rdata),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    ts_mem_model i_mem_model (
        .clk       (clk),
        .mem_rd    (mem_rd),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("ERR %0t: %s expected %0h got %0h", $time, what, expected, actual);
        $display("TEST FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_on_timeout(input string what);
        $display("TEST FAIL");
        $display("timeout: %s", what);
        $fatal(1, "run stopped by timeout");
    endtask

    function automatic int credits_left();
        return TASK_DEPTH + returns - sent;
    endfunction

    // memory contents as the model defines them
    function automatic logic [DDATA_W-1:0] mem_word(input logic [DADDR_W-1:0] a);
        logic [DDATA_W-1:0] prod;
        prod = a[15:0] * 16'h9e37;
        return prod ^ 16'h5a5a;
    endfunction

    // pixel order within a word
    function automatic logic [3:0] word_nibble(input logic [DDATA_W-1:0] w, input int p);
        case (p)
            0:       return w[7:4];
            1:       return w[3:0];
            2:       return w[15:12];
            default: return w[11:8];
        endcase
    endfunction

    // expected line from the task list with later tasks on top
    function automatic void build_expected();
        task_t              t;
        logic [DADDR_W-1:0] base;
        logic [DDATA_W-1:0] w;
        logic [3:0]         nib;
        logic [XC_W-1:0]    pos;
        int                 n;
        foreach (exp_line[i])
            exp_line[i] = '0;
        foreach (task_list[k])
        begin
            t = task_list[k];
            base = DADDR_W'((int'(t.page) * 64 + int'(t.line)) * 128 + int'(t.addr) * 2);
            n = (int'(t.x_size) + 1) * 8;
            for (int i = 0; i < n; i++)
            begin
                w   = mem_word(base + DADDR_W'(i / 4));
                nib = word_nibble(w, i % 4);
                // flipped strips run down from the far end modulo 512
                if (t.flip)
                    pos = XC_W'(int'(t.x_coord) + int'(t.x_size) * 8 + 7 - i);
                else
                    pos = XC_W'(int'(t.x_coord) + i);
                if (nib != 4'd0)
                    exp_line[pos] = {t.pal, nib};
            end
        end
    endfunction

    function automatic task_t make_task(input logic [XC_W-1:0] xc, input logic [2:0] xs,
                                        input logic fl, input logic [5:0] ad,
                                        input logic [8:0] ln, input logic [7:0] pg,
                                        input logic [3:0] pl);
        task_t t;
        t.x_coord = xc;
        t.x_size  = xs;
        t.flip    = fl;
        t.addr    = ad;
        t.line    = ln;
        t.page    = pg;
        t.pal     = pl;
        return t;
    endfunction

    function automatic task_t random_task();
        task_t t;
        t.x_coord = XC_W'($urandom);
        t.x_size  = 3'($urandom);
        t.flip    = 1'($urandom);
        // strip stays inside its 128 word bitmap line
        t.addr    = 6'($urandom % 57);
        t.line    = 9'($urandom);
        t.page    = 8'($urandom);
        t.pal     = 4'($urandom);
        return t;
    endfunction

    // back to back while credits last
    task automatic send_task(input task_t t);
        int waited;
        if (credits_left() <= 0)
        begin
            @(posedge clk);
            task_valid <= 1'b0;
            waited = 0;
            while (credits_left() <= 0)
            begin
                @(negedge clk);
                waited++;
                if (waited > IDLE_TIMEOUT)
                    abort_on_timeout("no credit came back from the task queue");
            end
        end
        @(posedge clk);
        task_valid <= 1'b1;
        x_coord    <= t.x_coord;
        x_size     <= t.x_size;
        flip       <= t.flip;
        addr       <= t.addr;
        line       <= t.line;
        page       <= t.page;
        pal        <= t.pal;
        sent++;
        task_list.push_back(t);
    endtask

    task automatic stop_sending();
        @(posedge clk);
        task_valid <= 1'b0;
    endtask

    task automatic wait_for_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!idle)
        begin
            @(negedge clk);
            waited++;
            if (waited > IDLE_TIMEOUT)
                abort_on_timeout("renderer never went idle");
        end
    endtask

    // full scanout that also clears the buffer
    task automatic scan_out(input bit check);
        check_on = check;
        for (int a = 0; a < LINE_W; a++)
        begin
            @(posedge clk);
            rd_en   <= 1'b1;
            rd_addr <= XC_W'(a);
        end
        @(posedge clk);
        rd_en <= 1'b0;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic render_and_compare();
        stop_sending();
        wait_for_idle();
        build_expected();
        scan_out(1'b1);
        task_list.delete();
        assert (credits_left() == TASK_DEPTH)
        else
            report_mismatch("credits after line", TASK_DEPTH, credits_left());
    endtask

    // line_start while tasks are queued and rendering
    task automatic flush_mid_burst();
        int waited;
        @(posedge clk);
        task_valid <= 1'b0;
        line_start <= 1'b1;
        @(posedge clk);
        line_start <= 1'b0;
        wait_for_idle();
        waited = 0;
        while (credits_left() != TASK_DEPTH)
        begin
            @(negedge clk);
            waited++;
            if (waited > IDLE_TIMEOUT)
                abort_on_timeout("credits of flushed tasks never came back");
        end
        // partial strips are unpredictable and only get cleared
        scan_out(1'b0);
        task_list.delete();
    endtask

    // returns are counted half a cycle after the pulse
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (credit_return)
                returns <= returns + 1;
            assert (credits_left() >= 0 && credits_left() <= TASK_DEPTH)
            else
                report_mismatch("credits held by host", TASK_DEPTH, credits_left());
        end
    end

    // read data belongs to the address of the previous edge
    always @(posedge clk)
    begin
        if (reset)
            chk_valid <= 1'b0;
        else
            chk_valid <= rd_en;
        chk_addr <= rd_addr;
    end

    always @(negedge clk)
    begin
        if (chk_valid && check_on)
        begin
            assert (rd_data == exp_line[chk_addr])
            else
                report_mismatch($sformatf("line[%0d]", chk_addr),
                                int'(exp_line[chk_addr]), int'(rd_data));
        end
    end

    initial
    begin
        void'($urandom(32'hf461));
        reset      = 1'b1;
        line_start = 1'b0;
        task_valid = 1'b0;
        x_coord    = '0;
        x_size     = '0;
        flip       = 1'b0;
        addr       = '0;
        line       = '0;
        page       = '0;
        pal        = '0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        // line buffer powers up with junk
        scan_out(1'b0);

        // one plain strip of every size
        for (int s = 0; s < 8; s++)
        begin
            send_task(make_task(XC_W'(s * 53 + 7), 3'(s), 1'b0, 6'(s * 5), 9'(s * 31),
                                8'(s * 17 + 2), 4'(s + 1)));
            render_and_compare();
        end

        // mirrored strips where two wrap past 511
        send_task(make_task(9'd40, 3'd2, 1'b1, 6'd3, 9'd12, 8'd5, 4'h6));
        send_task(make_task(9'd500, 3'd3, 1'b1, 6'd20, 9'd200, 8'd77, 4'h9));
        send_task(make_task(9'd505, 3'd0, 1'b1, 6'd50, 9'd511, 8'd255, 4'hc));
        render_and_compare();

        // overlapping strips where holes in later ones show earlier pixels
        send_task(make_task(9'd100, 3'd7, 1'b0, 6'd1, 9'd3, 8'd9, 4'h1));
        send_task(make_task(9'd120, 3'd2, 1'b0, 6'd7, 9'd44, 8'd130, 4'h2));
        send_task(make_task(9'd110, 3'd1, 1'b1, 6'd33, 9'd301, 8'd61, 4'h3));
        render_and_compare();

        // random bursts limited only by credits
        for (int b = 0; b < 3; b++)
        begin
            for (int i = 0; i < 10; i++)
                send_task(random_task());
            render_and_compare();
        end

        // empty line right after a full scanout
        render_and_compare();

        // restart mid burst and then render a clean line
        for (int i = 0; i < 6; i++)
            send_task(random_task());
        flush_mid_burst();
        for (int i = 0; i < 5; i++)
            send_task(random_task());
        render_and_compare();

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: ts_line.f
rtl/ts_pkg.sv
rtl/ts_task_queue.sv
rtl/dram_slot_timer.sv
rtl/ts_render.sv
rtl/ts_line_buf.sv
rtl/ts_line_top.sv
dv/ts_mem_model.sv
dv/ts_line_tb.sv

// File: Makefile
# Verilator build and run of the scanline renderer testbench

VERILATOR ?= verilator
TOP       ?= ts_line_tb
SEED      ?= 1
FLIST     ?= ts_line.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# a $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJ_DIR)
